/* hdl/prf_defs.svh */
// ======================================================================
// Sizing macros for the physical register file
// ======================================================================

`ifndef PRF_DEFS_SVH
`define PRF_DEFS_SVH

// Number of physical registers
`define PRF_ENTRIES 64

// Register value width
`define PRF_XLEN 32

// Width of a reorder buffer entry ID
`define PRF_ROB_ID_W 7

// Instructions renamed per cycle
`define PRF_DISPATCH_W 2

// Writeback channels on the CDB (ALU, MUL, LSQ)
`define PRF_CDB_N 3

`endif

/* hdl/prf_pkg.sv */
// ======================================================================
// Shared types for the physical register file
// ======================================================================

`include "prf_defs.svh"

package prf_pkg;

    // Width of a physical register index
    localparam int PRF_IDX_W = $clog2(`PRF_ENTRIES);

    // Physical register index
    typedef logic [PRF_IDX_W-1:0] preg_idx_t;

    // Reorder buffer entry ID
    typedef logic [`PRF_ROB_ID_W-1:0] rob_id_t;

    // Register value
    typedef logic [`PRF_XLEN-1:0] prf_word_t;

    // One table entry, value in the upper bits
    typedef struct packed {
        prf_word_t value;
        logic      busy;
        rob_id_t   rob_id;
    } prf_entry_t;

    // CDB channels, listed from highest to lowest priority
    typedef enum logic [1:0] {
        CDB_ALU = 2'd0,
        CDB_MUL = 2'd1,
        CDB_LSQ = 2'd2
    } cdb_src_e;

endpackage

/* hdl/cdb_if.sv */
// ======================================================================
// Common data bus carrying the three writeback channels
// ======================================================================

`timescale 1ns/1ps

`include "prf_defs.svh"

interface cdb_if
    import prf_pkg::*;
();

    // One element per channel, indexed by cdb_src_e
    logic      valid  [`PRF_CDB_N];
    preg_idx_t preg   [`PRF_CDB_N];
    prf_word_t value  [`PRF_CDB_N];
    rob_id_t   rob_id [`PRF_CDB_N];

    // Storage only needs the write target and data
    modport sink_wr (
        input valid,
        input preg,
        input value
    );

    // Bypass also returns the producer's ROB ID
    modport sink_fwd (
        input valid,
        input preg,
        input value,
        input rob_id
    );

endinterface

/* hdl/prf_storage.sv */
// ======================================================================
// Physical register table with rename marking and CDB writeback
// ======================================================================

`timescale 1ns/1ps

`include "prf_defs.svh"

module prf_storage
    import prf_pkg::*;
(
    input  logic       clk,
    input  logic       rst,

    // Rename marking from the dispatch lanes
    input  logic       ren_valid  [`PRF_DISPATCH_W],
    input  preg_idx_t  ren_preg   [`PRF_DISPATCH_W],
    input  rob_id_t    ren_rob_id [`PRF_DISPATCH_W],

    // Writeback channels
    cdb_if.sink_wr     cdb,

    // Current table contents, read by the bypass ports
    output prf_entry_t entries    [`PRF_ENTRIES]
);

    prf_entry_t entries_d [`PRF_ENTRIES];

    // Per-entry hit vectors, rebuilt every cycle
    logic [`PRF_DISPATCH_W-1:0] ren_hit [`PRF_ENTRIES];
    logic [`PRF_CDB_N-1:0]      wb_hit  [`PRF_ENTRIES];

    // Decode which lanes and channels address each entry
    always_comb begin
        for (int i = 0; i < `PRF_ENTRIES; i++) begin
            for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
                ren_hit[i][l] = ren_valid[l] && (ren_preg[l] == preg_idx_t'(i));
            end
            for (int c = 0; c < `PRF_CDB_N; c++) begin
                wb_hit[i][c] = cdb.valid[c] && (cdb.preg[c] == preg_idx_t'(i));
            end
        end
    end

    // Next state of every entry
    //   renames first, lane 1 applied after lane 0 so it wins
    //   writebacks after renames, so a completing result clears busy
    always_comb begin
        for (int i = 0; i < `PRF_ENTRIES; i++) begin
            entries_d[i] = entries[i];

            for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
                if (ren_hit[i][l]) begin
                    entries_d[i].busy   = 1'b1;
                    entries_d[i].rob_id = ren_rob_id[l];
                end
            end

            // Walk from lowest priority up so the ALU lands last
            for (int c = int'(CDB_LSQ); c >= int'(CDB_ALU); c--) begin
                if (wb_hit[i][c]) begin
                    entries_d[i].value = cdb.value[c];
                    entries_d[i].busy  = 1'b0;
                end
            end
        end
    end

    // ROB ID is kept on writeback so the last producer stays visible
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `PRF_ENTRIES; i++) begin
                entries[i] <= '0;
            end
        end else begin
            for (int i = 0; i < `PRF_ENTRIES; i++) begin
                entries[i] <= entries_d[i];
            end
        end
    end

endmodule

/* hdl/prf_bypass.sv */
// ======================================================================
// Read port with same-cycle forwarding from the CDB
// ======================================================================

`timescale 1ns/1ps

`include "prf_defs.svh"

module prf_bypass
    import prf_pkg::*;
(
    // Source register being read
    input  preg_idx_t  src_preg,

    // Stored table state
    input  prf_entry_t entries [`PRF_ENTRIES],

    // Results being written this cycle
    cdb_if.sink_fwd    cdb,

    // Operand as seen by dispatch
    output prf_entry_t operand
);

    // Channels that write the requested register right now
    logic [`PRF_CDB_N-1:0] hit;

    always_comb begin
        for (int c = 0; c < `PRF_CDB_N; c++) begin
            hit[c] = cdb.valid[c] && (cdb.preg[c] == src_preg);
        end
    end

    // Default to the stored entry, then let forwarded data override it.
    // Scanning from LSQ toward ALU leaves the highest priority hit in place.
    always_comb begin
        operand = entries[src_preg];
        for (int c = int'(CDB_LSQ); c >= int'(CDB_ALU); c--) begin
            if (hit[c]) begin
                operand.value  = cdb.value[c];
                operand.busy   = 1'b0;
                operand.rob_id = cdb.rob_id[c];
            end
        end
    end

endmodule

/* hdl/phys_reg_file.sv */
// ======================================================================
// Physical register file top: storage plus four forwarding read ports
// ======================================================================

`timescale 1ns/1ps

`include "prf_defs.svh"

module phys_reg_file
    import prf_pkg::*;
(
    input  logic                       clk,
    input  logic                       rst,

    // Rename marking, one destination per lane
    input  logic [`PRF_DISPATCH_W-1:0] dispatch_valid,
    input  preg_idx_t                  dispatch_rd     [`PRF_DISPATCH_W],
    input  rob_id_t                    dispatch_rob_id [`PRF_DISPATCH_W],

    // Source indices, two per lane
    input  preg_idx_t                  dispatch_rs1    [`PRF_DISPATCH_W],
    input  preg_idx_t                  dispatch_rs2    [`PRF_DISPATCH_W],

    // Writeback channels, ordered ALU, MUL, LSQ
    input  logic [`PRF_CDB_N-1:0]      cdb_valid,
    input  preg_idx_t                  cdb_preg        [`PRF_CDB_N],
    input  prf_word_t                  cdb_value       [`PRF_CDB_N],
    input  rob_id_t                    cdb_rob_id      [`PRF_CDB_N],

    // Source operands, combinational from the indices and CDB
    output prf_entry_t                 rs1_data        [`PRF_DISPATCH_W],
    output prf_entry_t                 rs2_data        [`PRF_DISPATCH_W]
);

    // Sources read per lane (rs1 and rs2)
    localparam int SRC_N = 2;

    logic       ren_valid [`PRF_DISPATCH_W];
    prf_entry_t entries   [`PRF_ENTRIES];

    cdb_if cdb ();

    // Unpack the valid vectors into per-element arrays
    always_comb begin
        for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
            ren_valid[l] = dispatch_valid[l];
        end
        for (int c = 0; c < `PRF_CDB_N; c++) begin
            cdb.valid[c] = cdb_valid[c];
        end
    end

    assign cdb.preg   = cdb_preg;
    assign cdb.value  = cdb_value;
    assign cdb.rob_id = cdb_rob_id;

    prf_storage u_storage (
        .clk        (clk),
        .rst        (rst),
        .ren_valid  (ren_valid),
        .ren_preg   (dispatch_rd),
        .ren_rob_id (dispatch_rob_id),
        .cdb        (cdb.sink_wr),
        .entries    (entries)
    );

    // One bypass port per lane and source
    for (genvar l = 0; l < `PRF_DISPATCH_W; l++) begin : g_lane
        for (genvar s = 0; s < SRC_N; s++) begin : g_src
            preg_idx_t  src_preg;
            prf_entry_t operand;

            if (s == 0) begin : g_rs1
                assign src_preg    = dispatch_rs1[l];
                assign rs1_data[l] = operand;
            end else begin : g_rs2
                assign src_preg    = dispatch_rs2[l];
                assign rs2_data[l] = operand;
            end

            prf_bypass u_bypass (
                .src_preg (src_preg),
                .entries  (entries),
                .cdb      (cdb.sink_fwd),
                .operand  (operand)
            );
        end
    end

endmodule

/* bench/tb_phys_reg_file.sv */
// ======================================================================
// Testbench for the physical register file: directed and random tests
// against a reference model, with watchdog and error summary
// ======================================================================

`timescale 1ns/1ps

`include "prf_defs.svh"

module tb_phys_reg_file
    import prf_pkg::*;
();

    localparam int CLK_PERIOD    = 8;
    localparam int RANDOM_CYCLES = 200;
    // Cycles spent by all tests, reset included
    localparam int TEST_CYCLES   = 8 + 16 + 5 + 9 + 1 + 4 + RANDOM_CYCLES + 1;
    localparam int TIMEOUT_NS    = (TEST_CYCLES + 100) * CLK_PERIOD;

    logic                       clk;
    logic                       rst;
    logic [`PRF_DISPATCH_W-1:0] dispatch_valid;
    preg_idx_t                  dispatch_rd     [`PRF_DISPATCH_W];
    rob_id_t                    dispatch_rob_id [`PRF_DISPATCH_W];
    preg_idx_t                  dispatch_rs1    [`PRF_DISPATCH_W];
    preg_idx_t                  dispatch_rs2    [`PRF_DISPATCH_W];
    logic [`PRF_CDB_N-1:0]      cdb_valid;
    preg_idx_t                  cdb_preg        [`PRF_CDB_N];
    prf_word_t                  cdb_value       [`PRF_CDB_N];
    rob_id_t                    cdb_rob_id      [`PRF_CDB_N];
    prf_entry_t                 rs1_data        [`PRF_DISPATCH_W];
    prf_entry_t                 rs2_data        [`PRF_DISPATCH_W];

    // Reference copy of the table, state after the last clock edge
    prf_entry_t  model [`PRF_ENTRIES];
    int          errors;
    logic [31:0] rng_state;

    phys_reg_file uut (
        .clk             (clk),
        .rst             (rst),
        .dispatch_valid  (dispatch_valid),
        .dispatch_rd     (dispatch_rd),
        .dispatch_rob_id (dispatch_rob_id),
        .dispatch_rs1    (dispatch_rs1),
        .dispatch_rs2    (dispatch_rs2),
        .cdb_valid       (cdb_valid),
        .cdb_preg        (cdb_preg),
        .cdb_value       (cdb_value),
        .cdb_rob_id      (cdb_rob_id),
        .rs1_data        (rs1_data),
        .rs2_data        (rs2_data)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic prf_entry_t make_entry(input prf_word_t value, input logic busy,
                                              input rob_id_t rob_id);
        prf_entry_t e;
        e.value  = value;
        e.busy   = busy;
        e.rob_id = rob_id;
        return e;
    endfunction

    // Expected operand: first valid CDB hit in ALU, MUL, LSQ order, else stored entry
    function automatic prf_entry_t expected_read(input preg_idx_t idx);
        for (int c = 0; c < `PRF_CDB_N; c++) begin
            if (cdb_valid[c] && cdb_preg[c] == idx) begin
                return make_entry(cdb_value[c], 1'b0, cdb_rob_id[c]);
            end
        end
        return model[idx];
    endfunction

    task automatic check_value(input string name, input prf_entry_t got, input prf_entry_t exp);
        assert (got === exp) else begin
            errors++;
            $display("Fail t=%0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    task automatic check_reads();
        for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
            check_value($sformatf("rs1_data[%0d]", l), rs1_data[l], expected_read(dispatch_rs1[l]));
            check_value($sformatf("rs2_data[%0d]", l), rs2_data[l], expected_read(dispatch_rs2[l]));
        end
    endtask

    // Renames in lane order, then the highest priority writeback per register
    task automatic update_model();
        for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
            if (dispatch_valid[l]) begin
                model[dispatch_rd[l]].busy   = 1'b1;
                model[dispatch_rd[l]].rob_id = dispatch_rob_id[l];
            end
        end
        for (int i = 0; i < `PRF_ENTRIES; i++) begin
            for (int c = 0; c < `PRF_CDB_N; c++) begin
                if (cdb_valid[c] && cdb_preg[c] == preg_idx_t'(i)) begin
                    model[i].value = cdb_value[c];
                    model[i].busy  = 1'b0;
                    break;
                end
            end
        end
    endtask

    task automatic clear_inputs();
        dispatch_valid <= '0;
        cdb_valid      <= '0;
        for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
            dispatch_rd[l]     <= '0;
            dispatch_rob_id[l] <= '0;
            dispatch_rs1[l]    <= '0;
            dispatch_rs2[l]    <= '0;
        end
        for (int c = 0; c < `PRF_CDB_N; c++) begin
            cdb_preg[c]   <= '0;
            cdb_value[c]  <= '0;
            cdb_rob_id[c] <= '0;
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        clear_inputs();
    endtask

    task automatic rename(input int lane, input int rd, input int rob);
        dispatch_valid[lane]  <= 1'b1;
        dispatch_rd[lane]     <= preg_idx_t'(rd);
        dispatch_rob_id[lane] <= rob_id_t'(rob);
    endtask

    task automatic writeback(input int ch, input int preg, input prf_word_t value, input int rob);
        cdb_valid[ch]  <= 1'b1;
        cdb_preg[ch]   <= preg_idx_t'(preg);
        cdb_value[ch]  <= value;
        cdb_rob_id[ch] <= rob_id_t'(rob);
    endtask

    task automatic set_reads(input int a, input int b, input int c, input int d);
        dispatch_rs1[0] <= preg_idx_t'(a);
        dispatch_rs2[0] <= preg_idx_t'(b);
        dispatch_rs1[1] <= preg_idx_t'(c);
        dispatch_rs2[1] <= preg_idx_t'(d);
    endtask

    // Check reads mid-cycle, then advance the model past the coming edge
    task automatic step();
        @(negedge clk);
        check_reads();
        update_model();
    endtask

    task automatic test_reset();
        for (int k = 0; k < `PRF_ENTRIES / 4; k++) begin
            next_cycle();
            set_reads(4 * k, 4 * k + 1, 4 * k + 2, 4 * k + 3);
            step();
            for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
                check_value("rs1_data after reset", rs1_data[l], '0);
                check_value("rs2_data after reset", rs2_data[l], '0);
            end
        end
    endtask

    task automatic test_rename();
        next_cycle();
        writeback(CDB_ALU, 5, 32'hcafe_0005, 0);
        step();
        // Same-cycle reads still see the old entry
        next_cycle();
        rename(0, 5, 7'h11);
        set_reads(5, 5, 5, 5);
        step();
        next_cycle();
        set_reads(5, 5, 5, 5);
        step();
        check_value("rs1_data[0]", rs1_data[0], make_entry(32'hcafe_0005, 1'b1, 7'h11));
        next_cycle();
        rename(0, 9, 7'h21);
        rename(1, 9, 7'h22);
        step();
        next_cycle();
        set_reads(9, 9, 9, 9);
        step();
        check_value("rs2_data[1]", rs2_data[1], make_entry('0, 1'b1, 7'h22));
    endtask

    task automatic test_writeback();
        int        r;
        int        q;
        prf_word_t v;
        for (int c = 0; c < `PRF_CDB_N; c++) begin
            r = 12 + c;
            q = 'h30 + c;
            v = 32'hbeef_0000 | prf_word_t'(c + 1);
            next_cycle();
            rename(0, r, q);
            step();
            // CDB carries a different ROB ID than the one stored at rename
            next_cycle();
            writeback(c, r, v, q + 8);
            step();
            next_cycle();
            set_reads(r, r, r, r);
            step();
            check_value("rs1_data[0]", rs1_data[0], make_entry(v, 1'b0, rob_id_t'(q)));
        end
    endtask

    task automatic test_forward();
        next_cycle();
        writeback(CDB_MUL, 20, 32'h2020_2020, 7'h44);
        set_reads(20, 21, 20, 5);
        step();
        check_value("rs1_data[1]", rs1_data[1], make_entry(32'h2020_2020, 1'b0, 7'h44));
        check_value("rs2_data[1]", rs2_data[1], make_entry(32'hcafe_0005, 1'b1, 7'h11));
    endtask

    task automatic test_priority();
        next_cycle();
        writeback(CDB_ALU, 30, 32'haaaa_0001, 7'h50);
        writeback(CDB_MUL, 30, 32'hbbbb_0001, 7'h51);
        writeback(CDB_LSQ, 30, 32'hcccc_0001, 7'h52);
        set_reads(30, 30, 30, 30);
        step();
        check_value("rs1_data[0]", rs1_data[0], make_entry(32'haaaa_0001, 1'b0, 7'h50));
        next_cycle();
        writeback(CDB_MUL, 31, 32'hbbbb_0002, 7'h53);
        writeback(CDB_LSQ, 31, 32'hcccc_0002, 7'h54);
        set_reads(30, 31, 31, 30);
        step();
        check_value("rs1_data[0]", rs1_data[0], make_entry(32'haaaa_0001, 1'b0, '0));
        check_value("rs2_data[0]", rs2_data[0], make_entry(32'hbbbb_0002, 1'b0, 7'h53));
        // Rename and writeback of one register in the same cycle
        next_cycle();
        rename(0, 32, 7'h60);
        writeback(CDB_LSQ, 32, 32'hdddd_0003, 7'h60);
        set_reads(31, 31, 31, 31);
        step();
        check_value("rs2_data[1]", rs2_data[1], make_entry(32'hbbbb_0002, 1'b0, '0));
        next_cycle();
        set_reads(32, 32, 32, 32);
        step();
        check_value("rs1_data[1]", rs1_data[1], make_entry(32'hdddd_0003, 1'b0, 7'h60));
    endtask

    // Indices limited to 32 registers so lanes and channels collide often
    task automatic test_random();
        logic [31:0] r;
        for (int n = 0; n < RANDOM_CYCLES; n++) begin
            next_cycle();
            for (int l = 0; l < `PRF_DISPATCH_W; l++) begin
                r = xorshift32();
                if (r[0]) rename(l, int'(r[8:4]), int'(r[22:16]));
            end
            for (int c = 0; c < `PRF_CDB_N; c++) begin
                r = xorshift32();
                if (r[0]) writeback(c, int'(r[8:4]), xorshift32(), int'(r[22:16]));
            end
            r = xorshift32();
            set_reads(int'(r[4:0]), int'(r[12:8]), int'(r[20:16]), int'(r[28:24]));
            step();
        end
    endtask

    initial begin
        errors    = 0;
        rng_state = 32'd52951;
        rst      <= 1'b1;
        clear_inputs();
        for (int i = 0; i < `PRF_ENTRIES; i++) begin
            model[i] = '0;
        end
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        test_rename();
        test_writeback();
        test_forward();
        test_priority();
        test_random();
        next_cycle();
        $display("Tests finished with %0d error(s)", errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
        $display("=== FAIL ===");
        $finish;
    end

endmodule

/* tb.f */
+incdir+hdl
hdl/prf_pkg.sv
hdl/cdb_if.sv
hdl/prf_storage.sv
hdl/prf_bypass.sv
hdl/phys_reg_file.sv
bench/tb_phys_reg_file.sv

/* Bender.yml */
package:
  name: phys_reg_file

export_include_dirs:
  - hdl

sources:
  - include_dirs:
      - hdl
    files:
      - hdl/prf_pkg.sv
      - hdl/cdb_if.sv
      - hdl/prf_storage.sv
      - hdl/prf_bypass.sv
      - hdl/phys_reg_file.sv

  - target: test
    include_dirs:
      - hdl
    files:
      - bench/tb_phys_reg_file.sv
